// ==== files.f ====
lcStatePkg.sv
lcLaneIf.sv
lcVecDispatch.sv
lcStateDecode.sv
lcDecCollect.sv
lcStateCheckTop.sv
tbLcChecker.sv
tbLcStateCheck.sv

// ==== lcDecCollect.sv ====
// In-order drain of the decode lanes onto the output port
// Consumer must never return more credits than it was sent results
// Each send also frees one input credit for the sender
`default_nettype none

module lcDecCollect #(
  parameter int unsigned NumLanes   = 3,
  parameter int unsigned OutCredits = 2
) (
  input  wire                  clk_i,
  input  wire                  rstN_i,
  lcResIf.collector            resIf[NumLanes],
  input  wire                  outCredit_i,
  output logic                 outValid_o,
  output lcStatePkg::lcResultT outRes_o,
  output logic                 inCredit_o
);
  import lcStatePkg::*;

  localparam int unsigned PtrW = (NumLanes > 1) ? $clog2(NumLanes) : 1;
  localparam int unsigned CntW = $clog2(OutCredits + 1);

  logic [PtrW-1:0]     rdPtr;
  logic [CntW-1:0]     credCnt;
  logic [NumLanes-1:0] fullVec;
  lcResultT            resArr[NumLanes];
  logic                send;
  logic                sentQ;

  // Gather lane state and hand out the take strobe
  for (genvar g = 0; g < NumLanes; g++) begin : genLaneIo
    assign fullVec[g]    = resIf[g].full;
    assign resArr[g]     = resIf[g].res;
    assign resIf[g].take = send && (rdPtr == PtrW'(g));
  end

  // Oldest lane ready and the consumer has room
  assign send = fullVec[rdPtr] && (credCnt != '0);

  ////////////////////////////////////////////////////////////
  // Pointer, credits and output strobe
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      rdPtr   <= '0;
      credCnt <= CntW'(OutCredits);
      sentQ   <= 1'b0;
    end else begin
      sentQ <= send;
      if (send) begin
        if (rdPtr == PtrW'(NumLanes - 1)) begin
          rdPtr <= '0;
        end else begin
          rdPtr <= rdPtr + 1'b1;
        end
      end
      // Return and spend in one cycle cancel out
      if (outCredit_i && !send) begin
        credCnt <= credCnt + 1'b1;
      end else if (!outCredit_i && send) begin
        credCnt <= credCnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (send) begin
      outRes_o <= resArr[rdPtr];
    end
  end

  assign outValid_o = sentQ;
  // Lane was freed on the same edge
  assign inCredit_o = sentQ;

endmodule

`default_nettype wire

// ==== lcLaneIf.sv ====
// Per-lane handshakes between dispatcher, decode lane and collector
// No clock inside, all sampling happens in the attached modules
`default_nettype none

// Record going into a lane, taken when valid is high on a rising edge
interface lcRecIf;
  import lcStatePkg::*;

  logic     valid;
  lcRecordT rec;
  // Lane still holds an untaken result
  logic     busy;

  modport dispatcher (output valid, output rec, input busy);
  modport lane       (input valid, input rec, output busy);
endinterface

// Result coming out of a lane, full drops on the edge where take is high
interface lcResIf;
  import lcStatePkg::*;

  logic     full;
  lcResultT res;
  logic     take;

  modport lane      (output full, output res, input take);
  modport collector (input full, input res, output take);
endinterface

`default_nettype wire

// ==== lcStateCheckTop.sv ====
// Life-cycle state record checker with credit flow control on both sides
// Sender starts with NumLanes credits, consumer side starts with OutCredits
// Results leave in acceptance order, two edges after acceptance at the earliest
`default_nettype none

module lcStateCheckTop #(
  parameter int unsigned NumLanes   = 3,
  parameter int unsigned OutCredits = 2
) (
  input  wire                       clk_i,
  input  wire                       rstN_i,
  // Record input
  input  wire                       inValid_i,
  input  wire                       inStateValid_i,
  input  lcStatePkg::lcStateE       inState_i,
  input  lcStatePkg::lcCntE         inCnt_i,
  input  lcStatePkg::lcTxT          inSecretsValid_i,
  input  lcStatePkg::fsmStateE      inFsmState_i,
  output logic                      inCredit_o,
  // Result output
  output logic                      outValid_o,
  output lcStatePkg::extDecLcStateT outDecState_o,
  output lcStatePkg::decLcIdStateE  outIdState_o,
  output lcStatePkg::decLcCntT      outCnt_o,
  output lcStatePkg::stateErrT      outErr_o,
  input  wire                       outCredit_i,
  output logic                      credErr_o
);
  import lcStatePkg::*;

  lcRecordT inRec;
  lcResultT outRes;

  assign inRec = '{
    stateValid:   inStateValid_i,
    state:        inState_i,
    cnt:          inCnt_i,
    secretsValid: inSecretsValid_i,
    fsmState:     inFsmState_i
  };

  lcRecIf recIf[NumLanes] ();
  lcResIf resIf[NumLanes] ();

  lcVecDispatch #(
    .NumLanes (NumLanes)
  ) uDispatch (
    .clk_i     (clk_i),
    .rstN_i    (rstN_i),
    .inValid_i (inValid_i),
    .rec_i     (inRec),
    .recIf     (recIf),
    .credErr_o (credErr_o)
  );

  // Identical decode lanes
  for (genvar g = 0; g < NumLanes; g++) begin : genLane
    lcStateDecode uLane (
      .clk_i  (clk_i),
      .rstN_i (rstN_i),
      .recIf  (recIf[g]),
      .resIf  (resIf[g])
    );
  end

  lcDecCollect #(
    .NumLanes   (NumLanes),
    .OutCredits (OutCredits)
  ) uCollect (
    .clk_i       (clk_i),
    .rstN_i      (rstN_i),
    .resIf       (resIf),
    .outCredit_i (outCredit_i),
    .outValid_o  (outValid_o),
    .outRes_o    (outRes),
    .inCredit_o  (inCredit_o)
  );

  assign outDecState_o = outRes.decState;
  assign outIdState_o  = outRes.idState;
  assign outCnt_o      = outRes.cnt;
  assign outErr_o      = outRes.err;

endmodule

`default_nettype wire

// ==== lcStateDecode.sv ====
// One decode lane: combinational check of a life-cycle record plus a result holder
// A new record is only offered while the lane is empty
// Result stays put until the collector takes it
`default_nettype none

module lcStateDecode (
  input  wire  clk_i,
  input  wire  rstN_i,
  lcRecIf.lane recIf,
  lcResIf.lane resIf
);
  import lcStatePkg::*;

  lcRecordT      rec;
  extDecLcStateT decState;
  decLcIdStateE  idState;
  decLcCntT      decCnt;
  stateErrT      err;
  logic          full;

  assign rec = recIf.rec;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Everything invalid unless proven otherwise
    decState = lcRepState(DecLcStInvalid);
    decCnt   = DecLcCntInvalid;
    idState  = DecLcIdInvalid;
    err      = '0;

    unique case (rec.fsmState)
      // Nothing decoded while the controller is in reset
      ResetSt: ;
      // Transient states are not part of the fuse vector
      EscalateSt:  decState = lcRepState(DecLcStEscalate);
      PostTransSt: decState = lcRepState(DecLcStPostTrans);
      InvalidSt:   decState = lcRepState(DecLcStInvalid);
      ScrapSt:     decState = lcRepState(DecLcStScrap);
      default: begin
        // Fuse partition must report valid outside of reset
        err[0] = ~rec.stateValid;

        unique case (rec.state)
          LcStRaw:           decState = lcRepState(DecLcStRaw);
          LcStTestUnlocked0: decState = lcRepState(DecLcStTestUnlocked0);
          LcStTestLocked0:   decState = lcRepState(DecLcStTestLocked0);
          LcStTestUnlocked1: decState = lcRepState(DecLcStTestUnlocked1);
          LcStDev:           decState = lcRepState(DecLcStDev);
          LcStProd:          decState = lcRepState(DecLcStProd);
          LcStProdEnd:       decState = lcRepState(DecLcStProdEnd);
          LcStRma:           decState = lcRepState(DecLcStRma);
          LcStScrap:         decState = lcRepState(DecLcStScrap);
          default:           err[1] = 1'b1;
        endcase

        unique case (rec.cnt)
          LcCnt0:  decCnt = 4'd0;
          LcCnt1:  decCnt = 4'd1;
          LcCnt2:  decCnt = 4'd2;
          LcCnt3:  decCnt = 4'd3;
          LcCnt4:  decCnt = 4'd4;
          LcCnt5:  decCnt = 4'd5;
          LcCnt6:  decCnt = 4'd6;
          LcCnt7:  decCnt = 4'd7;
          LcCnt8:  decCnt = 4'd8;
          default: err[2] = 1'b1;
        endcase

        // Secrets flag gives the ID state
        unique case (rec.secretsValid)
          Off:     idState = DecLcIdBlank;
          On:      idState = DecLcIdPersonalized;
          default: err[3] = 1'b1;
        endcase

        // Leaving Raw always costs at least one transition
        if (rec.state != LcStRaw && rec.cnt == LcCnt0) begin
          err[4] = 1'b1;
        end

        // Personalized parts must be in a mission or end-of-life state
        if (lcTxTestTrueStrict(rec.secretsValid) &&
            !(rec.state inside {LcStDev, LcStProd, LcStProdEnd, LcStRma, LcStScrap})) begin
          err[5] = 1'b1;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Result holder
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      full <= 1'b0;
    end else if (recIf.valid) begin
      full <= 1'b1;
    end else if (resIf.take) begin
      full <= 1'b0;
    end
  end

  // Payload only loads on acceptance
  always_ff @(posedge clk_i) begin
    if (recIf.valid) begin
      resIf.res <= '{decState: decState, idState: idState, cnt: decCnt, err: err};
    end
  end

  assign resIf.full = full;
  assign recIf.busy = full;

endmodule

`default_nettype wire

// ==== lcStatePkg.sv ====
// Shared encodings and types for the life-cycle state checker
// Reduced state set of nine persistent states and counts 0 to 8
// Sparse values are local to this design and do not match any fuse map
// Decoded codes and the invalid count value 15 are exposed on the outputs
`default_nettype none

package lcStatePkg;

  ////////////////////////////////////////////////////////////
  // Persistent vector encodings as read from fuses
  ////////////////////////////////////////////////////////////

  // Sparse 16-bit state words, any other value is invalid
  typedef enum logic [15:0] {
    LcStRaw           = 16'h0000,
    LcStTestUnlocked0 = 16'h3a5c,
    LcStTestLocked0   = 16'h5c93,
    LcStTestUnlocked1 = 16'h96e1,
    LcStDev           = 16'hc7a2,
    LcStProd          = 16'h2bd9,
    LcStProdEnd       = 16'he15e,
    LcStRma           = 16'h7d34,
    LcStScrap         = 16'hffff
  } lcStateE;

  // Sparse transition count words
  typedef enum logic [15:0] {
    LcCnt0 = 16'h0000,
    LcCnt1 = 16'h1c6a,
    LcCnt2 = 16'h3e5d,
    LcCnt3 = 16'h53b7,
    LcCnt4 = 16'h67c1,
    LcCnt5 = 16'h8a2f,
    LcCnt6 = 16'h9d74,
    LcCnt7 = 16'hb5e9,
    LcCnt8 = 16'hf6d3
  } lcCntE;

  // Multi-bit boolean, anything but these two patterns is invalid
  typedef enum logic [3:0] {
    On  = 4'b0101,
    Off = 4'b1010
  } lcTxT;

  // Controller FSM states that come with each record
  typedef enum logic [2:0] {
    ResetSt, IdleSt, EscalateSt, PostTransSt, InvalidSt, ScrapSt
  } fsmStateE;

  ////////////////////////////////////////////////////////////
  // Decoded representation
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    DecLcStRaw           = 5'd0,
    DecLcStTestUnlocked0 = 5'd1,
    DecLcStTestLocked0   = 5'd2,
    DecLcStTestUnlocked1 = 5'd3,
    DecLcStDev           = 5'd4,
    DecLcStProd          = 5'd5,
    DecLcStProdEnd       = 5'd6,
    DecLcStRma           = 5'd7,
    DecLcStScrap         = 5'd8,
    DecLcStEscalate      = 5'd9,
    DecLcStPostTrans     = 5'd10,
    DecLcStInvalid       = 5'd11
  } decLcStateE;

  // Redundant copies of the decoded state
  parameter int unsigned DecLcStateNumRep = 3;
  typedef decLcStateE [DecLcStateNumRep-1:0] extDecLcStateT;

  typedef enum logic [1:0] {
    DecLcIdBlank        = 2'd0,
    DecLcIdPersonalized = 2'd1,
    DecLcIdInvalid      = 2'd2
  } decLcIdStateE;

  typedef logic [3:0] decLcCntT;
  // All ones marks an undecodable count
  parameter decLcCntT DecLcCntInvalid = 4'd15;

  // Bit 0 valid low, 1 state, 2 count, 3 secrets, 4 zero count, 5 personalized too early
  typedef logic [5:0] stateErrT;

  typedef struct packed {
    logic     stateValid;
    lcStateE  state;
    lcCntE    cnt;
    lcTxT     secretsValid;
    fsmStateE fsmState;
  } lcRecordT;

  typedef struct packed {
    extDecLcStateT decState;
    decLcIdStateE  idState;
    decLcCntT      cnt;
    stateErrT      err;
  } lcResultT;

  // Same code in every redundant copy
  function automatic extDecLcStateT lcRepState(decLcStateE st);
    extDecLcStateT rep;
    for (int k = 0; k < DecLcStateNumRep; k++) begin
      rep[k] = st;
    end
    return rep;
  endfunction

  // Only the exact On pattern counts as true
  function automatic logic lcTxTestTrueStrict(lcTxT v);
    return v == On;
  endfunction

endpackage

`default_nettype wire

// ==== lcVecDispatch.sv ====
// Round-robin steering of incoming records to the decode lanes
// Sender must respect credits; a record hitting a busy lane is lost
// The credit error flag stays set until reset
`default_nettype none

module lcVecDispatch #(
  parameter int unsigned NumLanes = 3
) (
  input  wire                  clk_i,
  input  wire                  rstN_i,
  input  wire                  inValid_i,
  input  lcStatePkg::lcRecordT rec_i,
  lcRecIf.dispatcher           recIf[NumLanes],
  output logic                 credErr_o
);
  import lcStatePkg::*;

  localparam int unsigned PtrW = (NumLanes > 1) ? $clog2(NumLanes) : 1;

  logic [PtrW-1:0]     wrPtr;
  logic [NumLanes-1:0] busyVec;
  logic                accept;
  logic                overrun;

  // Fan out record and gated valid to every lane
  for (genvar g = 0; g < NumLanes; g++) begin : genLaneIo
    assign recIf[g].rec   = rec_i;
    assign recIf[g].valid = inValid_i && (wrPtr == PtrW'(g)) && !recIf[g].busy;
    assign busyVec[g]     = recIf[g].busy;
  end

  assign accept  = inValid_i && !busyVec[wrPtr];
  // Busy target means the sender ran past its credits
  assign overrun = inValid_i && busyVec[wrPtr];

  ////////////////////////////////////////////////////////////
  // Pointer and sticky error
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      wrPtr     <= '0;
      credErr_o <= 1'b0;
    end else begin
      // Advance only past lanes that really got a record
      if (accept) begin
        if (wrPtr == PtrW'(NumLanes - 1)) begin
          wrPtr <= '0;
        end else begin
          wrPtr <= wrPtr + 1'b1;
        end
      end
      if (overrun) begin
        credErr_o <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/bin/sh
# Build with Verilator and run; exit status follows the pass message
verilator --binary --timing --timescale 1ns/1ps -f files.f \
  --top-module tbLcStateCheck -o simLcStateCheck &&
  ./obj_dir/simLcStateCheck | tee /dev/stderr | grep -q "Simulation passed" &&
  echo "runSim: pass" ||
  { echo "runSim: fail"; exit 1; }

// ==== tbLcChecker.sv ====
// Result monitor for the life-cycle state checker
// Expected results are queued by the testbench in send order
// Samples all DUT outputs on the falling clock edge
`default_nettype none

module tbLcChecker (
  input  wire                       clk_i,
  input  wire                       rstN_i,
  input  wire                       outValid_i,
  input  lcStatePkg::extDecLcStateT outDecState_i,
  input  lcStatePkg::decLcIdStateE  outIdState_i,
  input  lcStatePkg::decLcCntT      outCnt_i,
  input  lcStatePkg::stateErrT      outErr_i,
  input  wire                       inCredit_i,
  input  wire                       credErr_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import lcStatePkg::*;

  string    nameQ[$];
  lcResultT expQ[$];
  int       mismatchCnt  = 0;
  int       otherCnt     = 0;
  int       creditPulses = 0;
  bit       overrunSent  = 1'b0;
  bit       credErrSeen  = 1'b0;

  // Called by the testbench for every record it sends
  task automatic pushExpected(input string name, input lcResultT exp);
    nameQ.push_back(name);
    expQ.push_back(exp);
  endtask

  function automatic int pending();
    return expQ.size();
  endfunction

  // From here on a raised credit error is wanted
  task automatic markOverrun();
    overrunSent = 1'b1;
  endtask

  task automatic compareField(input string testName, input string field,
                              input logic [15:0] expVal, input logic [15:0] actVal);
    if (expVal !== actVal) begin
      $display("CHECK FAILED %s %s expected %h actual %h", testName, field, expVal, actVal);
      mismatchCnt++;
    end
  endtask

  task automatic checkResult();
    string    name;
    lcResultT exp;
    if (expQ.size() == 0) begin
      $display("A result arrived while no record was pending, err %h", outErr_i);
      otherCnt++;
    end else begin
      name = nameQ.pop_front();
      exp  = expQ.pop_front();
      // All redundant copies are compared at once
      compareField(name, "decState", 16'(exp.decState), 16'(outDecState_i));
      compareField(name, "idState", 16'(exp.idState), 16'(outIdState_i));
      compareField(name, "cnt", 16'(exp.cnt), 16'(outCnt_i));
      compareField(name, "err", 16'(exp.err), 16'(outErr_i));
    end
  endtask

  always @(negedge clk_i) begin
    if (rstN_i) begin
      if (inCredit_i) begin
        creditPulses++;
      end
      // Report only the first rise
      if (credErr_i && !overrunSent && !credErrSeen) begin
        $display("credErr_o went high although the sender obeyed its credits");
        otherCnt++;
        credErrSeen = 1'b1;
      end
      if (outValid_i) begin
        checkResult();
      end
    end
  end

  // End of run bookkeeping
  task automatic finalCheck(input int expRecords);
    if (expQ.size() != 0) begin
      $display("%0d expected results never arrived", expQ.size());
      otherCnt++;
    end
    if (creditPulses != expRecords) begin
      $display("inCredit_o pulsed %0d times for %0d records", creditPulses, expRecords);
      otherCnt++;
    end
    if (!credErr_i) begin
      $display("credErr_o stayed low after the record sent without a credit");
      otherCnt++;
    end
  endtask

endmodule

`default_nettype wire

// ==== tbLcStateCheck.sv ====
// Testbench for the life-cycle state checker
// Output credits come back after seeded random gaps
// Ends with one record sent without a credit into full lanes
`default_nettype none

module tbLcStateCheck;
  timeunit 1ns;
  timeprecision 1ps;
  import lcStatePkg::*;

  localparam int NumLanes       = 3;
  localparam int OutCredits     = 2;
  localparam int NumRows        = 17;
  // Enough to fill the lanes and use up every output credit
  localparam int NumFill        = NumLanes + OutCredits;
  localparam int ClkPeriod      = 100;
  localparam int WatchdogCycles = (NumRows + NumFill + 1) * 40 + 200;

  // Garbage vector parts
  localparam lcStateE BadSt  = lcStateE'(16'h1234);
  localparam lcCntE   BadCnt = lcCntE'(16'h4444);
  localparam lcTxT    BadTx  = lcTxT'(4'h0);

  typedef struct packed {
    lcRecordT     rec;
    decLcStateE   expSt;
    decLcIdStateE expId;
    decLcCntT     expCnt;
    stateErrT     expErr;
  } rowT;

  logic          clk         = 1'b0;
  logic          rstN;
  logic          inValid;
  logic          inStateValid;
  lcStateE       inState;
  lcCntE         inCnt;
  lcTxT          inSecretsValid;
  fsmStateE      inFsmState;
  logic          inCredit;
  logic          outValid;
  extDecLcStateT outDecState;
  decLcIdStateE  outIdState;
  decLcCntT      outCnt;
  stateErrT      outErr;
  logic          outCredit   = 1'b0;
  logic          credErr;

  rowT   tblRows[$];
  string tblNames[$];
  int    inCreditCnt = 0;
  int    sentCnt     = 0;
  int    owed        = 0;
  int    gap         = 0;
  bit    holdCredits = 1'b0;

  always #(ClkPeriod / 2) clk = ~clk;

  lcStateCheckTop #(
    .NumLanes   (NumLanes),
    .OutCredits (OutCredits)
  ) UUT (
    .clk_i            (clk),
    .rstN_i           (rstN),
    .inValid_i        (inValid),
    .inStateValid_i   (inStateValid),
    .inState_i        (inState),
    .inCnt_i          (inCnt),
    .inSecretsValid_i (inSecretsValid),
    .inFsmState_i     (inFsmState),
    .inCredit_o       (inCredit),
    .outValid_o       (outValid),
    .outDecState_o    (outDecState),
    .outIdState_o     (outIdState),
    .outCnt_o         (outCnt),
    .outErr_o         (outErr),
    .outCredit_i      (outCredit),
    .credErr_o        (credErr)
  );

  tbLcChecker uChecker (
    .clk_i         (clk),
    .rstN_i        (rstN),
    .outValid_i    (outValid),
    .outDecState_i (outDecState),
    .outIdState_i  (outIdState),
    .outCnt_i      (outCnt),
    .outErr_i      (outErr),
    .inCredit_i    (inCredit),
    .credErr_i     (credErr)
  );

  ////////////////////////////////////////////////////////////
  // Credit models for both sides
  ////////////////////////////////////////////////////////////

  // Returned input credits as seen by the sender
  always @(posedge clk) begin
    if (inCredit) begin
      inCreditCnt++;
    end
  end

  // Consumer gives each output credit back after a random gap
  always @(negedge clk) begin
    if (outValid) begin
      owed++;
    end
    outCredit = 1'b0;
    if (gap > 0) begin
      gap--;
    end else if (owed > 0 && !holdCredits) begin
      outCredit = 1'b1;
      owed--;
      gap = $urandom_range(8, 1);
    end
  end

  task automatic addRow(input string name, input logic stValid, input lcStateE st,
                        input lcCntE cnt, input lcTxT sec, input fsmStateE fsm,
                        input decLcStateE expSt, input decLcIdStateE expId,
                        input decLcCntT expCnt, input stateErrT expErr);
    rowT r;
    r = '{'{stValid, st, cnt, sec, fsm}, expSt, expId, expCnt, expErr};
    tblRows.push_back(r);
    tblNames.push_back(name);
  endtask

  // Overrun skips the credit wait and expects no result
  task automatic sendRecord(input rowT r, input string name, input bit overrun);
    lcResultT exp;
    @(negedge clk);
    while (!overrun && (NumLanes + inCreditCnt - sentCnt) <= 0) begin
      @(negedge clk);
    end
    inStateValid   = r.rec.stateValid;
    inState        = r.rec.state;
    inCnt          = r.rec.cnt;
    inSecretsValid = r.rec.secretsValid;
    inFsmState     = r.rec.fsmState;
    inValid        = 1'b1;
    if (overrun) begin
      uChecker.markOverrun();
    end else begin
      for (int k = 0; k < DecLcStateNumRep; k++) begin
        exp.decState[k] = r.expSt;
      end
      exp.idState = r.expId;
      exp.cnt     = r.expCnt;
      exp.err     = r.expErr;
      uChecker.pushExpected(name, exp);
      sentCnt++;
    end
    @(negedge clk);
    inValid = 1'b0;
  endtask

  // Every result out and every output credit back
  task automatic waitIdle();
    @(posedge clk);
    while (uChecker.pending() != 0 || owed != 0 || outCredit) begin
      @(posedge clk);
    end
  endtask

  initial begin
    void'($urandom(32'h1a63cdb2));
    rstN           = 1'b0;
    inValid        = 1'b0;
    inStateValid   = 1'b0;
    inState        = LcStRaw;
    inCnt          = LcCnt0;
    inSecretsValid = Off;
    inFsmState     = ResetSt;

    // Valid persistent states
    addRow("rawBlank", 1'b1, LcStRaw, LcCnt0, Off, IdleSt,
           DecLcStRaw, DecLcIdBlank, 4'd0, 6'h00);
    addRow("devBlank", 1'b1, LcStDev, LcCnt3, Off, IdleSt,
           DecLcStDev, DecLcIdBlank, 4'd3, 6'h00);
    addRow("devPers", 1'b1, LcStDev, LcCnt4, On, IdleSt,
           DecLcStDev, DecLcIdPersonalized, 4'd4, 6'h00);
    addRow("prodPers", 1'b1, LcStProd, LcCnt5, On, IdleSt,
           DecLcStProd, DecLcIdPersonalized, 4'd5, 6'h00);
    addRow("rmaPers", 1'b1, LcStRma, LcCnt8, On, IdleSt,
           DecLcStRma, DecLcIdPersonalized, 4'd8, 6'h00);
    addRow("tu0Blank", 1'b1, LcStTestUnlocked0, LcCnt1, Off, IdleSt,
           DecLcStTestUnlocked0, DecLcIdBlank, 4'd1, 6'h00);
    // FSM state overrides whatever the vector holds
    addRow("escalate", 1'b0, BadSt, BadCnt, BadTx, EscalateSt,
           DecLcStEscalate, DecLcIdInvalid, 4'd15, 6'h00);
    addRow("postTrans", 1'b0, BadSt, BadCnt, BadTx, PostTransSt,
           DecLcStPostTrans, DecLcIdInvalid, 4'd15, 6'h00);
    addRow("invalidSt", 1'b0, BadSt, BadCnt, BadTx, InvalidSt,
           DecLcStInvalid, DecLcIdInvalid, 4'd15, 6'h00);
    addRow("scrapSt", 1'b0, BadSt, BadCnt, BadTx, ScrapSt,
           DecLcStScrap, DecLcIdInvalid, 4'd15, 6'h00);
    addRow("resetSt", 1'b1, LcStDev, LcCnt2, Off, ResetSt,
           DecLcStInvalid, DecLcIdInvalid, 4'd15, 6'h00);
    // One corrupt field each
    addRow("validLow", 1'b0, LcStDev, LcCnt2, Off, IdleSt,
           DecLcStDev, DecLcIdBlank, 4'd2, 6'h01);
    addRow("badState", 1'b1, BadSt, LcCnt2, Off, IdleSt,
           DecLcStInvalid, DecLcIdBlank, 4'd2, 6'h02);
    addRow("badCnt", 1'b1, LcStDev, BadCnt, Off, IdleSt,
           DecLcStDev, DecLcIdBlank, 4'd15, 6'h04);
    addRow("badSecrets", 1'b1, LcStDev, LcCnt2, BadTx, IdleSt,
           DecLcStDev, DecLcIdInvalid, 4'd2, 6'h08);
    // Consistency rules
    addRow("prodCnt0", 1'b1, LcStProd, LcCnt0, Off, IdleSt,
           DecLcStProd, DecLcIdBlank, 4'd0, 6'h10);
    addRow("tl0Pers", 1'b1, LcStTestLocked0, LcCnt2, On, IdleSt,
           DecLcStTestLocked0, DecLcIdPersonalized, 4'd2, 6'h20);

    // Reset held over four rising edges
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    for (int i = 0; i < NumRows; i++) begin
      sendRecord(tblRows[i], tblNames[i], 1'b0);
    end
    waitIdle();

    // Stall the consumer until every lane is full and the sender is out of credits
    @(posedge clk);
    holdCredits = 1'b1;
    for (int i = 0; i < NumFill; i++) begin
      sendRecord(tblRows[i], {tblNames[i], "Fill"}, 1'b0);
    end
    sendRecord(tblRows[NumFill], "overrun", 1'b1);

    @(posedge clk);
    holdCredits = 1'b0;
    waitIdle();
    // Room for a stray result to show up
    repeat (10) @(negedge clk);
    uChecker.finalCheck(NumRows + NumFill);

    $display("Errors: %0d mismatches, %0d other failures",
             uChecker.mismatchCnt, uChecker.otherCnt);
    if (uChecker.mismatchCnt == 0 && uChecker.otherCnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles with results still outstanding",
             WatchdogCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
